//--- design/drc_pkg.sv
package drc_pkg;
    localparam int DVP_DATA_W   = 8;
    localparam int DIM_W        = 12;
    localparam int GRAY_W       = 8;
    localparam int WORD_W       = 32;
    localparam int PIX_PER_WORD = 4;

    // Word offsets, decoded from adr[3:2]
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_SIZE   = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;
    localparam logic [1:0] REG_FCOUNT = 2'd3;

    localparam int CTRL_EN       = 0;
    localparam int CTRL_MSK_DONE = 1;
    localparam int CTRL_MSK_ERR  = 2;
    localparam int SIZE_H_LSB    = 16;   // Height field, width sits at bit 0

    // Sticky status, write 1 to clear
    localparam int ST_DONE = 0;
    localparam int ST_ERR  = 1;
    localparam int ST_OVF  = 2;
    localparam int ST_W    = 3;

    typedef union packed {
        struct packed {
            logic [DVP_DATA_W-1:0] hi;   // First byte on the camera
            logic [DVP_DATA_W-1:0] lo;
        } byte_pair;
        struct packed {
            logic [4:0] r;
            logic [5:0] g;
            logic [4:0] b;
        } rgb565;
    } pixel_u;

    typedef struct packed {
        pixel_u pix;
        logic   sof;
        logic   last;
    } rgb_beat_t;

    typedef struct packed {
        logic [GRAY_W-1:0] gray;
        logic              last;
    } gray_beat_t;

    typedef struct packed {
        logic             enable;
        logic             irq_msk_done;
        logic             irq_msk_err;
        logic [DIM_W-1:0] width;
        logic [DIM_W-1:0] height;
    } drc_cfg_t;

    typedef struct packed {
        logic done;
        logic err;
        logic ovf;
    } drc_evt_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        adr;
        logic [WORD_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_rsp_t;
endpackage

//--- design/drc_dvp_capture.sv
module drc_dvp_capture #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [drc_pkg::DVP_DATA_W-1:0] dvp_d_i,
    input  logic                           dvp_pclk_i,
    input  logic                           dvp_href_i,
    input  logic                           dvp_vsync_i,
    output drc_pkg::rgb_beat_t             pix_o,
    output logic                           pix_valid_o,
    input  logic                           pix_ready_i,
    output logic                           ovf_o
);
    import drc_pkg::*;

    logic [SYNC_STAGES-1:0]                 pclk_sync;
    logic [SYNC_STAGES-1:0]                 href_sync;
    logic [SYNC_STAGES-1:0]                 vsync_sync;
    logic [SYNC_STAGES-1:0][DVP_DATA_W-1:0] d_sync;
    logic                                   pclk_q;
    logic                                   vsync_q;
    logic                                   pclk_rise;
    logic                                   vsync_rise;
    logic                                   byte_take;
    logic                                   pix_done;
    logic                                   lo_phase_q;   // Next byte closes the pair
    logic                                   sof_pend_q;
    logic [DVP_DATA_W-1:0]                  hi_q;

    assign pclk_rise  = pclk_sync[SYNC_STAGES-1] && !pclk_q;
    assign vsync_rise = vsync_sync[SYNC_STAGES-1] && !vsync_q;
    assign byte_take  = pclk_rise && href_sync[SYNC_STAGES-1] && !vsync_rise;
    assign pix_done   = byte_take && lo_phase_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pclk_sync   <= '0;
            href_sync   <= '0;
            vsync_sync  <= '0;
            pclk_q      <= 1'b0;
            vsync_q     <= 1'b0;
            lo_phase_q  <= 1'b0;
            sof_pend_q  <= 1'b0;
            pix_valid_o <= 1'b0;
            ovf_o       <= 1'b0;
        end else begin
            pclk_sync  <= {pclk_sync[SYNC_STAGES-2:0], dvp_pclk_i};
            href_sync  <= {href_sync[SYNC_STAGES-2:0], dvp_href_i};
            vsync_sync <= {vsync_sync[SYNC_STAGES-2:0], dvp_vsync_i};
            pclk_q     <= pclk_sync[SYNC_STAGES-1];
            vsync_q    <= vsync_sync[SYNC_STAGES-1];
            ovf_o      <= 1'b0;
            if (pix_valid_o && pix_ready_i)
                pix_valid_o <= 1'b0;
            if (vsync_rise) begin
                lo_phase_q <= 1'b0;   // New frame restarts byte pairing
                sof_pend_q <= 1'b1;
            end else if (byte_take) begin
                lo_phase_q <= !lo_phase_q;
            end
            if (pix_done) begin
                pix_valid_o <= 1'b1;
                sof_pend_q  <= 1'b0;
                ovf_o       <= pix_valid_o && !pix_ready_i;   // Held pixel lost
            end
        end
    end

    always_ff @(posedge clk) begin
        d_sync <= {d_sync[SYNC_STAGES-2:0], dvp_d_i};
        if (byte_take && !lo_phase_q)
            hi_q <= d_sync[SYNC_STAGES-1];
        if (pix_done) begin
            pix_o.pix.byte_pair.hi <= hi_q;
            pix_o.pix.byte_pair.lo <= d_sync[SYNC_STAGES-1];
            pix_o.sof              <= sof_pend_q;
            pix_o.last             <= 1'b0;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        pix_valid_o && !pix_ready_i |=> pix_valid_o && ($stable(pix_o) || ovf_o));
endmodule

//--- design/drc_frame_ctrl.sv
module drc_frame_ctrl (
    input  logic               clk,
    input  logic               rst_n_i,
    input  drc_pkg::drc_cfg_t  cfg_i,
    input  drc_pkg::rgb_beat_t in_i,
    input  logic               in_valid_i,
    output logic               in_ready_o,
    output drc_pkg::rgb_beat_t out_o,
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output drc_pkg::drc_evt_t  evt_o
);
    import drc_pkg::*;

    logic             in_frame_q;
    logic [DIM_W-1:0] col_q;
    logic [DIM_W-1:0] row_q;
    logic [DIM_W-1:0] col_cur;
    logic [DIM_W-1:0] row_cur;
    logic             accept;
    logic             start;
    logic             pass;
    logic             col_end;
    logic             last_hit;

    assign in_ready_o = out_ready_i || !out_valid_o;
    assign accept     = in_valid_i && in_ready_o;
    assign start      = accept && in_i.sof && cfg_i.enable;
    assign pass       = start || (accept && in_frame_q);   // Others are dropped
    assign col_cur    = start ? '0 : col_q;
    assign row_cur    = start ? '0 : row_q;
    assign col_end    = col_cur == cfg_i.width - 1'b1;
    assign last_hit   = col_end && (row_cur == cfg_i.height - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            in_frame_q  <= 1'b0;
            col_q       <= '0;
            row_q       <= '0;
            out_valid_o <= 1'b0;
            evt_o       <= '0;
        end else begin
            evt_o.done <= pass && last_hit;
            evt_o.err  <= start && in_frame_q;   // Frame cut by a new vsync
            evt_o.ovf  <= 1'b0;
            if (pass) begin
                out_valid_o <= 1'b1;
                in_frame_q  <= !last_hit;
                col_q       <= col_end ? '0 : col_cur + 1'b1;
                if (last_hit)
                    row_q <= '0;
                else
                    row_q <= col_end ? row_cur + 1'b1 : row_cur;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pass) begin
            out_o      <= in_i;
            out_o.last <= last_hit;
        end
    end

    a_evt_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(evt_o.done && evt_o.err));
endmodule

//--- design/drc_grayscale.sv
module drc_grayscale (
    input  logic                clk,
    input  logic                rst_n_i,
    input  drc_pkg::rgb_beat_t  in_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    output drc_pkg::gray_beat_t out_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);
    import drc_pkg::*;

    logic [GRAY_W-1:0] r8;
    logic [GRAY_W-1:0] g8;
    logic [GRAY_W-1:0] b8;
    logic [15:0]       luma_sum;
    logic              accept;

    // Replicate top bits to stretch the fields to full range
    assign r8 = {in_i.pix.rgb565.r, in_i.pix.rgb565.r[4:2]};
    assign g8 = {in_i.pix.rgb565.g, in_i.pix.rgb565.g[5:4]};
    assign b8 = {in_i.pix.rgb565.b, in_i.pix.rgb565.b[4:2]};

    assign luma_sum   = 16'd77 * r8 + 16'd150 * g8 + 16'd29 * b8;   // Weights sum to 256
    assign in_ready_o = out_ready_i || !out_valid_o;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            out_valid_o <= 1'b0;
        else if (accept)
            out_valid_o <= 1'b1;
        else if (out_ready_i)
            out_valid_o <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_o.gray <= luma_sum[15:8];
            out_o.last <= in_i.last;
        end
    end
endmodule

//--- design/drc_pixel_packer.sv
module drc_pixel_packer (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  drc_pkg::gray_beat_t        in_i,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    output logic [drc_pkg::WORD_W-1:0] word_o,
    output logic                       word_last_o,
    output logic                       word_valid_o,
    input  logic                       word_ready_i
);
    import drc_pkg::*;

    localparam int SLOT_W = $clog2(PIX_PER_WORD);

    logic [SLOT_W-1:0] slot_q;
    logic              accept;
    logic              word_done;

    assign in_ready_o = !word_valid_o;   // Stall while a full word waits
    assign accept     = in_valid_i && in_ready_o;
    assign word_done  = in_i.last || (slot_q == SLOT_W'(PIX_PER_WORD - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            slot_q       <= '0;
            word_valid_o <= 1'b0;
            word_last_o  <= 1'b0;
        end else begin
            if (word_valid_o && word_ready_i)
                word_valid_o <= 1'b0;
            if (accept) begin
                slot_q <= word_done ? '0 : slot_q + 1'b1;
                if (word_done) begin
                    word_valid_o <= 1'b1;
                    word_last_o  <= in_i.last;
                end
            end
        end
    end

    // First pixel clears the word, so a short last word is zero-filled
    always_ff @(posedge clk) begin
        if (accept) begin
            if (slot_q == '0)
                word_o <= WORD_W'(in_i.gray);
            else
                word_o[slot_q*GRAY_W +: GRAY_W] <= in_i.gray;
        end
    end

    a_word_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        word_valid_o && !word_ready_i |=>
            word_valid_o && $stable(word_o) && $stable(word_last_o));
endmodule

//--- design/drc_regmap.sv
module drc_regmap #(
    parameter int DEF_WIDTH  = 640,
    parameter int DEF_HEIGHT = 480
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  drc_pkg::wb_req_t  wb_i,
    output drc_pkg::wb_rsp_t  wb_o,
    input  drc_pkg::drc_evt_t evt_i,
    output drc_pkg::drc_cfg_t cfg_o,
    output logic              irq_o
);
    import drc_pkg::*;

    drc_cfg_t          cfg_q;
    logic [ST_W-1:0]   status_q;
    logic [ST_W-1:0]   status_set;
    logic [ST_W-1:0]   status_clr;
    logic [WORD_W-1:0] fcount_q;
    logic [WORD_W-1:0] rd_mux;
    logic [WORD_W-1:0] rdata_q;
    logic [1:0]        reg_sel;
    logic              ack_q;
    logic              access;
    logic              wr_en;

    assign reg_sel = wb_i.adr[3:2];
    assign access  = wb_i.cyc && wb_i.stb && !ack_q;   // Not yet acknowledged
    assign wr_en   = access && wb_i.we;

    always_comb begin
        status_set          = '0;
        status_set[ST_DONE] = evt_i.done;
        status_set[ST_ERR]  = evt_i.err;
        status_set[ST_OVF]  = evt_i.ovf;
        status_clr          = '0;
        if (wr_en && reg_sel == REG_STATUS)
            status_clr = wb_i.dat[ST_W-1:0];
    end

    always_comb begin
        rd_mux = '0;
        case (reg_sel)
            REG_CTRL: begin
                rd_mux[CTRL_EN]       = cfg_q.enable;
                rd_mux[CTRL_MSK_DONE] = cfg_q.irq_msk_done;
                rd_mux[CTRL_MSK_ERR]  = cfg_q.irq_msk_err;
            end
            REG_SIZE: begin
                rd_mux[DIM_W-1:0]           = cfg_q.width;
                rd_mux[SIZE_H_LSB +: DIM_W] = cfg_q.height;
            end
            REG_STATUS: rd_mux[ST_W-1:0] = status_q;
            REG_FCOUNT: rd_mux = fcount_q;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q              <= 1'b0;
            cfg_q.enable       <= 1'b0;
            cfg_q.irq_msk_done <= 1'b0;
            cfg_q.irq_msk_err  <= 1'b0;
            cfg_q.width        <= DIM_W'(DEF_WIDTH);
            cfg_q.height       <= DIM_W'(DEF_HEIGHT);
            status_q           <= '0;
            fcount_q           <= '0;
        end else begin
            ack_q    <= access;
            status_q <= (status_q & ~status_clr) | status_set;   // Set beats clear
            if (evt_i.done)
                fcount_q <= fcount_q + 1'b1;
            if (wr_en) begin
                case (reg_sel)
                    REG_CTRL: begin
                        cfg_q.enable       <= wb_i.dat[CTRL_EN];
                        cfg_q.irq_msk_done <= wb_i.dat[CTRL_MSK_DONE];
                        cfg_q.irq_msk_err  <= wb_i.dat[CTRL_MSK_ERR];
                    end
                    REG_SIZE: begin
                        cfg_q.width  <= wb_i.dat[DIM_W-1:0];
                        cfg_q.height <= wb_i.dat[SIZE_H_LSB +: DIM_W];
                    end
                    default: ;   // FCOUNT is read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            rdata_q <= rd_mux;
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdata_q;
    assign cfg_o    = cfg_q;
    assign irq_o    = (status_q[ST_DONE] && cfg_q.irq_msk_done) ||
                      (status_q[ST_ERR] && cfg_q.irq_msk_err);

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_o.ack |=> !wb_o.ack);
endmodule

//--- design/dvp_rx_controller.sv
module dvp_rx_controller #(
    parameter int DEF_WIDTH  = 640,
    parameter int DEF_HEIGHT = 480
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [drc_pkg::DVP_DATA_W-1:0] dvp_d_i,
    input  logic                           dvp_pclk_i,
    input  logic                           dvp_href_i,
    input  logic                           dvp_vsync_i,
    input  drc_pkg::wb_req_t               wb_i,
    output drc_pkg::wb_rsp_t               wb_o,
    output logic [drc_pkg::WORD_W-1:0]     word_o,
    output logic                           word_last_o,
    output logic                           word_valid_o,
    input  logic                           word_ready_i,
    output logic                           irq_o
);
    import drc_pkg::*;

    rgb_beat_t  cap_pix;
    logic       cap_valid;
    logic       cap_ready;
    logic       cap_ovf;
    rgb_beat_t  frm_pix;
    logic       frm_valid;
    logic       frm_ready;
    gray_beat_t gray_pix;
    logic       gray_valid;
    logic       gray_ready;
    drc_cfg_t   cfg;
    drc_evt_t   frm_evt;
    drc_evt_t   evt;

    // Capture overflow joins the frame events
    assign evt = '{done: frm_evt.done, err: frm_evt.err, ovf: cap_ovf};

    drc_dvp_capture capture_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dvp_d_i     (dvp_d_i),
        .dvp_pclk_i  (dvp_pclk_i),
        .dvp_href_i  (dvp_href_i),
        .dvp_vsync_i (dvp_vsync_i),
        .pix_o       (cap_pix),
        .pix_valid_o (cap_valid),
        .pix_ready_i (cap_ready),
        .ovf_o       (cap_ovf)
    );

    drc_frame_ctrl frame_ctrl_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg),
        .in_i        (cap_pix),
        .in_valid_i  (cap_valid),
        .in_ready_o  (cap_ready),
        .out_o       (frm_pix),
        .out_valid_o (frm_valid),
        .out_ready_i (frm_ready),
        .evt_o       (frm_evt)
    );

    drc_grayscale grayscale_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_i        (frm_pix),
        .in_valid_i  (frm_valid),
        .in_ready_o  (frm_ready),
        .out_o       (gray_pix),
        .out_valid_o (gray_valid),
        .out_ready_i (gray_ready)
    );

    drc_pixel_packer packer_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_i         (gray_pix),
        .in_valid_i   (gray_valid),
        .in_ready_o   (gray_ready),
        .word_o       (word_o),
        .word_last_o  (word_last_o),
        .word_valid_o (word_valid_o),
        .word_ready_i (word_ready_i)
    );

    drc_regmap #(
        .DEF_WIDTH  (DEF_WIDTH),
        .DEF_HEIGHT (DEF_HEIGHT)
    ) regmap_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb_i),
        .wb_o    (wb_o),
        .evt_i   (evt),
        .cfg_o   (cfg),
        .irq_o   (irq_o)
    );
endmodule

//--- bench/dvp_rx_controller_tb.sv
module dvp_rx_controller_tb;
    import drc_pkg::*;

    localparam int DEF_W  = 8;
    localparam int DEF_H  = 4;
    localparam int N_ROWS = 5;

    typedef struct packed {
        logic [DIM_W-1:0] width;
        logic [DIM_W-1:0] height;
        logic [DIM_W-1:0] count;    // Pixels actually sent
        logic             msk_done;
        logic             msk_err;
        logic             enable;
        logic             stall;    // word_ready_i low for the whole frame
    } frame_row_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [DVP_DATA_W-1:0] dvp_d;
    logic                  dvp_pclk;
    logic                  dvp_href;
    logic                  dvp_vsync;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic [WORD_W-1:0]     word;
    logic                  word_last;
    logic                  word_valid;
    logic                  word_ready;
    logic                  irq;

    frame_row_t rows [N_ROWS];
    gray_beat_t exp_q [$];
    int         words_rx = 0;
    int         err_cnt  = 0;
    int         tmo_cnt  = 0;

    always #4 clk = ~clk;

    dvp_rx_controller #(
        .DEF_WIDTH  (DEF_W),
        .DEF_HEIGHT (DEF_H)
    ) dvp_rx_controller_inst (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .dvp_d_i      (dvp_d),
        .dvp_pclk_i   (dvp_pclk),
        .dvp_href_i   (dvp_href),
        .dvp_vsync_i  (dvp_vsync),
        .wb_i         (wb_req),
        .wb_o         (wb_rsp),
        .word_o       (word),
        .word_last_o  (word_last),
        .word_valid_o (word_valid),
        .word_ready_i (word_ready),
        .irq_o        (irq)
    );

    // BT.601 style weights on fields stretched to 8 bits
    function automatic logic [GRAY_W-1:0] luma_of(input logic [15:0] rgb);
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        int         sum;
        r8  = {rgb[15:11], rgb[15:13]};
        g8  = {rgb[10:5], rgb[10:9]};
        b8  = {rgb[4:0], rgb[4:2]};
        sum = 77 * r8 + 150 * g8 + 29 * b8;
        return GRAY_W'(sum / 256);
    endfunction

    task automatic report_timeout(input string what);
        tmo_cnt++;
        $display("Timeout at %0t: %s did not happen in time", $time, what);
    endtask

    task automatic check_word(input logic [WORD_W-1:0] got, input logic got_last,
                              input logic [WORD_W-1:0] exp, input logic exp_last);
        if (got !== exp || got_last !== exp_last) begin
            err_cnt++;
            $display("FAIL %0t: word %08h last %0b, expected %08h last %0b",
                     $time, got, got_last, exp, exp_last);
        end
    endtask

    task automatic check_reg(input string what, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: %s reads %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: irq_o is %0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic bus_access(input logic write, input logic [1:0] sel,
                              input logic [WORD_W-1:0] wdat, output logic [WORD_W-1:0] rdat);
        int n;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: {sel, 2'b00}, dat: wdat};
        for (n = 0; n < 20 && !wb_rsp.ack; n++)
            @(posedge clk);
        if (!wb_rsp.ack)
            report_timeout("Wishbone ack");
        rdat = wb_rsp.dat;
        wb_req <= '0;
    endtask

    // Compares one output word with the next queued gray pixels
    task automatic take_word();
        logic [WORD_W-1:0] exp_word;
        logic              exp_last;
        gray_beat_t        beat;
        exp_word = '0;
        exp_last = 1'b0;
        words_rx++;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("FAIL %0t: word %08h arrived with no pixel expected", $time, word);
        end else begin
            for (int k = 0; k < PIX_PER_WORD; k++) begin
                if (!exp_last && exp_q.size() > 0) begin
                    beat = exp_q.pop_front();
                    exp_word[k*GRAY_W +: GRAY_W] = beat.gray;
                    exp_last = beat.last;
                end
            end
            check_word(word, word_last, exp_word, exp_last);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && word_valid && word_ready)
            take_word();
    end

    task automatic send_byte(input logic [DVP_DATA_W-1:0] b);
        @(posedge clk);
        dvp_pclk <= 1'b0;
        dvp_d    <= b;
        repeat (4) @(posedge clk);
        dvp_pclk <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic send_frame(input int width, input int height, input int count,
                              input logic keep);
        logic [15:0] pix;
        int          p;
        @(posedge clk);
        dvp_vsync <= 1'b1;
        repeat (16) @(posedge clk);
        dvp_vsync <= 1'b0;
        repeat (16) @(posedge clk);
        for (p = 0; p < count; p++) begin
            pix = 16'($urandom);
            if (p % width == 0) begin
                @(posedge clk);
                dvp_href <= 1'b1;
            end
            send_byte(pix[15:8]);   // Hi byte first
            send_byte(pix[7:0]);
            if (keep)
                exp_q.push_back('{gray: luma_of(pix), last: (p == width * height - 1)});
            if (p % width == width - 1 || p == count - 1) begin
                @(posedge clk);
                dvp_href <= 1'b0;
                repeat (12) @(posedge clk);
            end
        end
    endtask

    task automatic run_row(input frame_row_t row);
        logic [WORD_W-1:0] rd;
        logic [WORD_W-1:0] fc0;
        logic [WORD_W-1:0] size_w;
        logic [WORD_W-1:0] ctrl_w;
        logic              cut;
        int                wc0;
        int                n;
        cut    = int'(row.count) < int'(row.width) * int'(row.height);
        size_w = {4'b0, row.height, 4'b0, row.width};
        ctrl_w = {29'b0, row.msk_err, row.msk_done, row.enable};
        bus_access(1'b1, REG_SIZE, size_w, rd);
        bus_access(1'b0, REG_SIZE, '0, rd);
        check_reg("SIZE", rd, size_w);
        bus_access(1'b1, REG_CTRL, ctrl_w, rd);
        bus_access(1'b0, REG_CTRL, '0, rd);
        check_reg("CTRL", rd, ctrl_w);
        bus_access(1'b0, REG_FCOUNT, '0, fc0);
        wc0 = words_rx;
        word_ready <= !row.stall;
        send_frame(row.width, row.height, row.count, row.enable);
        if (cut)   // Full frame after the cut one closes it with err
            send_frame(row.width, row.height, row.width * row.height, row.enable);
        if (row.stall) begin
            bus_access(1'b0, REG_STATUS, '0, rd);
            check_reg("STATUS overflow bit", rd & WORD_W'(1 << ST_OVF), WORD_W'(1 << ST_OVF));
            word_ready <= 1'b1;
            for (n = 0; n < 100 && words_rx == wc0; n++)
                @(posedge clk);
            if (words_rx == wc0)
                report_timeout("first word after the stall");
            exp_q.delete();   // Rest of the frame was lost to overflow
        end else if (row.enable) begin
            for (n = 0; n < 400 && exp_q.size() > 0; n++)
                @(posedge clk);
            if (exp_q.size() > 0)
                report_timeout("output of all frame words");
            bus_access(1'b0, REG_STATUS, '0, rd);
            check_reg("STATUS after frame", rd, cut ? 32'h3 : 32'h1);
            check_irq(irq, row.msk_done || (cut && row.msk_err));
            bus_access(1'b0, REG_FCOUNT, '0, rd);
            check_reg("FCOUNT after frame", rd, fc0 + 1);
            bus_access(1'b1, REG_STATUS, 32'h7, rd);
            check_irq(irq, 1'b0);
            bus_access(1'b0, REG_STATUS, '0, rd);
            check_reg("STATUS after clear", rd, '0);
        end else begin
            repeat (64) @(posedge clk);
            check_reg("word count while disabled", words_rx, wc0);
            bus_access(1'b0, REG_FCOUNT, '0, rd);
            check_reg("FCOUNT while disabled", rd, fc0);
            bus_access(1'b0, REG_STATUS, '0, rd);
            check_reg("STATUS while disabled", rd, '0);
            check_irq(irq, 1'b0);
        end
    endtask

    initial begin
        logic [WORD_W-1:0] rd;
        rst_n      = 1'b0;
        dvp_d      = '0;
        dvp_pclk   = 1'b0;
        dvp_href   = 1'b0;
        dvp_vsync  = 1'b0;
        wb_req     = '0;
        word_ready = 1'b1;
        void'($urandom(52191));
        rows[0] = '{width: 6, height: 2, count: 12, msk_done: 1, msk_err: 0, enable: 1, stall: 0};
        rows[1] = '{width: 6, height: 2, count: 8, msk_done: 0, msk_err: 1, enable: 1, stall: 0};
        rows[2] = '{width: 5, height: 3, count: 15, msk_done: 0, msk_err: 0, enable: 1, stall: 0};
        rows[3] = '{width: 4, height: 3, count: 12, msk_done: 1, msk_err: 1, enable: 0, stall: 0};
        rows[4] = '{width: 6, height: 2, count: 12, msk_done: 0, msk_err: 0, enable: 1, stall: 1};
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        bus_access(1'b0, REG_STATUS, '0, rd);
        check_reg("STATUS after reset", rd, '0);
        bus_access(1'b0, REG_SIZE, '0, rd);
        check_reg("SIZE after reset", rd, {4'b0, DIM_W'(DEF_H), 4'b0, DIM_W'(DEF_W)});
        bus_access(1'b1, REG_FCOUNT, 32'h55, rd);
        bus_access(1'b0, REG_FCOUNT, '0, rd);
        check_reg("FCOUNT after write", rd, '0);
        check_irq(irq, 1'b0);
        for (int i = 0; i < N_ROWS; i++)
            run_row(rows[i]);
        $display("Checks done: %0d value errors, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end
endmodule

//--- dvp_rx_controller.f
design/drc_pkg.sv
design/drc_dvp_capture.sv
design/drc_frame_ctrl.sv
design/drc_grayscale.sv
design/drc_pixel_packer.sv
design/drc_regmap.sv
design/dvp_rx_controller.sv
bench/dvp_rx_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f dvp_rx_controller.f --top-module dvp_rx_controller_tb

./obj_dir/Vdvp_rx_controller_tb > sim.log
cat sim.log

if ! grep -q "All tests passed" sim.log; then
    exit 1
fi
